//--- logic/mc_params.svh
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// Tile grid
`define MC_NUM_ROWS 2
`define MC_NUM_COLS 2
`define MC_NUM_TILES (`MC_NUM_ROWS * `MC_NUM_COLS)

// Program image and tile memory
`define MC_MEM_WORDS 16
`define MC_ADDR_W 4
`define MC_DATA_W 32

// Packet coordinate widths
`define MC_X_W 1
`define MC_Y_W 1

`define MC_TILE_ID_PTR 3 // Word that gets the tile number

`endif

//--- logic/mc_pkg.sv
`default_nettype none

`include "mc_params.svh"

package mc_pkg;

  // Packet opcodes seen by the tiles
  typedef enum logic [1:0]
  {
    MC_OP_STORE    = 2'b01, // Write data to addr
    MC_OP_UNFREEZE = 2'b10  // Release the tile
  } mc_op_e;

  // Loader to tile packet, 40 bits
  typedef struct packed
  {
    mc_op_e                  op;
    logic [`MC_X_W-1:0]      x_cord;
    logic [`MC_Y_W-1:0]      y_cord;
    logic [`MC_ADDR_W-1:0]   addr;
    logic [`MC_DATA_W-1:0]   data;   // Zero for unfreeze
  } mc_packet_s;

endpackage

`default_nettype wire

//--- logic/mc_program_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_params.svh"

module mc_program_ram
  (
    input  wire                    clk_i,
    input  wire                    prog_we_i,
    input  wire [`MC_ADDR_W-1:0]   prog_addr_i,
    input  wire [`MC_DATA_W-1:0]   prog_data_i,
    input  wire [`MC_ADDR_W-1:0]   rd_addr_i,
    output logic [`MC_DATA_W-1:0]  rd_data_o
  );

  logic [`MC_DATA_W-1:0] mem_q [`MC_MEM_WORDS]; // Program image

  always_ff @(posedge clk_i)
  begin
    if (prog_we_i)
    begin
      mem_q[prog_addr_i] <= prog_data_i; // Host write
    end
  end

  assign rd_data_o = mem_q[rd_addr_i]; // Same-cycle read for the loader

endmodule

`default_nettype wire

//--- logic/mc_spmd_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_params.svh"

module mc_spmd_loader
  (
    input  wire                    clk_i,
    input  wire                    reset_i,
    input  wire                    start_i,
    output logic [`MC_ADDR_W-1:0]  rd_addr_o,
    input  wire [`MC_DATA_W-1:0]   rd_data_i,
    output mc_pkg::mc_packet_s     pkt_o,
    output logic                   valid_o,
    input  wire                    ready_i,
    output logic                   done_o
  );

  localparam int TILE_W = $clog2(`MC_NUM_TILES);

  typedef enum logic [1:0] {PH_IDLE, PH_LOAD, PH_UNFREEZE, PH_DONE} phase_e;

  phase_e              phase_q;
  logic [TILE_W-1:0]   tile_q;  // Destination tile
  logic [`MC_ADDR_W-1:0] word_q; // Word within the image
  logic                accept;
  logic                last_word;
  logic                last_tile;

  assign valid_o   = (phase_q == PH_LOAD) || (phase_q == PH_UNFREEZE);
  assign done_o    = (phase_q == PH_DONE);
  assign accept    = valid_o & ready_i; // State only moves on a transfer
  assign last_word = (word_q == `MC_ADDR_W'(`MC_MEM_WORDS - 1));
  assign last_tile = (tile_q == TILE_W'(`MC_NUM_TILES - 1));
  assign rd_addr_o = word_q;

  always_comb
  begin
    pkt_o.x_cord = `MC_X_W'(tile_q % `MC_NUM_COLS);
    pkt_o.y_cord = `MC_Y_W'(tile_q / `MC_NUM_COLS);
    pkt_o.addr   = word_q;
    if (phase_q == PH_UNFREEZE)
    begin
      pkt_o.op   = mc_pkg::MC_OP_UNFREEZE;
      pkt_o.data = '0;
    end
    else
    begin
      pkt_o.op   = mc_pkg::MC_OP_STORE;
      pkt_o.data = (word_q == `MC_ADDR_W'(`MC_TILE_ID_PTR)) ? `MC_DATA_W'(tile_q)
                                                             : rd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      phase_q <= PH_IDLE;
      tile_q  <= '0;
      word_q  <= '0;
    end
    else
    begin
      case (phase_q)
        PH_IDLE, PH_DONE:
        begin
          if (start_i)
          begin
            phase_q <= PH_LOAD;
            tile_q  <= '0;
            word_q  <= '0;
          end
        end
        PH_LOAD:
        begin
          if (accept)
          begin
            word_q <= last_word ? '0 : word_q + 1'b1;
            if (last_word)
            begin
              tile_q <= last_tile ? '0 : tile_q + 1'b1; // Tile-major walk
              if (last_tile)
              begin
                phase_q <= PH_UNFREEZE;
              end
            end
          end
        end
        default:
        begin
          if (accept)
          begin
            tile_q <= last_tile ? '0 : tile_q + 1'b1;
            if (last_tile)
            begin
              phase_q <= PH_DONE; // Done shows on this edge
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/mc_link_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_params.svh"

module mc_link_stage
  (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire mc_pkg::mc_packet_s    pkt_i,
    input  wire                        valid_i,
    output logic                       ready_o,
    input  wire                        net_ready_i,
    output mc_pkg::mc_packet_s         pkt_o,
    output logic [`MC_NUM_TILES-1:0]   deliver_o
  );

  localparam int TILE_W = $clog2(`MC_NUM_TILES);

  mc_pkg::mc_packet_s  pkt_q;   // Single network buffer
  logic                valid_q;
  logic [TILE_W-1:0]   dest;

  // Free slot, or the held packet leaves this cycle
  assign ready_o = ~valid_q | net_ready_i;
  assign pkt_o   = pkt_q;
  assign dest    = TILE_W'(pkt_q.y_cord * `MC_NUM_COLS + pkt_q.x_cord);

  always_comb
  begin
    deliver_o = '0;
    if (valid_q && net_ready_i)
    begin
      deliver_o[dest] = 1'b1; // One-hot strobe to the addressed tile
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_q <= 1'b0;
    end
    else if (ready_o)
    begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ready_o && valid_i)
    begin
      pkt_q <= pkt_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/mc_tile_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_params.svh"

module mc_tile_mem
  (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire                        deliver_i,
    input  wire mc_pkg::mc_packet_s    pkt_i,
    input  wire [`MC_ADDR_W-1:0]       rd_addr_i,
    output logic [`MC_DATA_W-1:0]      rd_data_o,
    output logic                       frozen_o
  );

  logic [`MC_DATA_W-1:0] mem_q [`MC_MEM_WORDS]; // Survives reset
  logic                  frozen_q;
  logic                  do_store;
  logic                  do_unfreeze;

  assign do_store    = deliver_i && (pkt_i.op == mc_pkg::MC_OP_STORE);
  assign do_unfreeze = deliver_i && (pkt_i.op == mc_pkg::MC_OP_UNFREEZE);

  always_ff @(posedge clk_i)
  begin
    if (do_store)
    begin
      mem_q[pkt_i.addr] <= pkt_i.data;
    end
  end

  // Tile holds off until the loader releases it
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      frozen_q <= 1'b1;
    end
    else if (do_unfreeze)
    begin
      frozen_q <= 1'b0;
    end
  end

  assign frozen_o  = frozen_q;
  assign rd_data_o = mem_q[rd_addr_i]; // Readback for checking

endmodule

`default_nettype wire

//--- logic/mc_loader_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_params.svh"

module mc_loader_top
  (
    input  wire                                        clk_i,
    input  wire                                        reset_i,
    input  wire                                        prog_we_i,
    input  wire [`MC_ADDR_W-1:0]                       prog_addr_i,
    input  wire [`MC_DATA_W-1:0]                       prog_data_i,
    input  wire                                        start_i,
    input  wire                                        net_ready_i,
    output logic                                       done_o,
    input  wire [`MC_ADDR_W-1:0]                       rd_addr_i,
    output logic [`MC_NUM_TILES-1:0][`MC_DATA_W-1:0]   rd_data_o,
    output logic [`MC_NUM_TILES-1:0]                   frozen_o
  );

  logic [`MC_ADDR_W-1:0]    ram_rd_addr;
  logic [`MC_DATA_W-1:0]    ram_rd_data;
  mc_pkg::mc_packet_s       ldr_pkt;     // Loader output
  logic                     ldr_valid;
  logic                     link_ready;
  mc_pkg::mc_packet_s       net_pkt;     // Broadcast to all tiles
  logic [`MC_NUM_TILES-1:0] deliver;

  mc_program_ram i_program_ram
  (
    .clk_i       (clk_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .rd_addr_i   (ram_rd_addr),
    .rd_data_o   (ram_rd_data)
  );

  mc_spmd_loader i_loader
  (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (start_i),
    .rd_addr_o (ram_rd_addr),
    .rd_data_i (ram_rd_data),
    .pkt_o     (ldr_pkt),
    .valid_o   (ldr_valid),
    .ready_i   (link_ready),
    .done_o    (done_o)
  );

  mc_link_stage i_link
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pkt_i       (ldr_pkt),
    .valid_i     (ldr_valid),
    .ready_o     (link_ready),
    .net_ready_i (net_ready_i),
    .pkt_o       (net_pkt),
    .deliver_o   (deliver)
  );

  for (genvar t = 0; t < `MC_NUM_TILES; t++)
  begin : g_tile
    mc_tile_mem i_tile
    (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .deliver_i (deliver[t]),
      .pkt_i     (net_pkt),
      .rd_addr_i (rd_addr_i),
      .rd_data_o (rd_data_o[t]),
      .frozen_o  (frozen_o[t])
    );
  end

endmodule

`default_nettype wire

//--- bench/tb_mc_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "mc_params.svh"

module tb_mc_loader;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_RUNS     = 2;
  localparam int STORES       = `MC_NUM_TILES * `MC_MEM_WORDS;
  // Two runs plus the reload after the mid-load reset
  localparam int WATCHDOG_CYCLES =
    (NUM_RUNS + 1) * (`MC_MEM_WORDS + (STORES + `MC_NUM_TILES) * 4 + 200);
  localparam logic [31:0] ALL_FROZEN = (1 << `MC_NUM_TILES) - 1;
  localparam logic [31:0] SEED       = 32'h1bc6_8802;
  localparam int LINE_LEN = 128;

  logic                                      clk_i;
  logic                                      reset_i;
  logic                                      prog_we_i;
  logic [`MC_ADDR_W-1:0]                     prog_addr_i;
  logic [`MC_DATA_W-1:0]                     prog_data_i;
  logic                                      start_i;
  logic                                      net_ready_i;
  logic                                      done_o;
  logic [`MC_ADDR_W-1:0]                     rd_addr_i;
  logic [`MC_NUM_TILES-1:0][`MC_DATA_W-1:0]  rd_data_o;
  logic [`MC_NUM_TILES-1:0]                  frozen_o;

  logic [`MC_DATA_W-1:0] prog_words [NUM_RUNS][`MC_MEM_WORDS]; // From the stimulus file
  logic [`MC_DATA_W-1:0] tile_ids [NUM_RUNS][`MC_NUM_TILES];
  int                    duty_tbl [NUM_RUNS];
  int                    ready_duty;  // Percent of cycles with net_ready_i high
  int                    error_count;
  int                    check_count;
  bit                    stim_ok;

  mc_loader_top i_dut
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .prog_we_i   (prog_we_i),
    .prog_addr_i (prog_addr_i),
    .prog_data_i (prog_data_i),
    .start_i     (start_i),
    .net_ready_i (net_ready_i),
    .done_o      (done_o),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o),
    .frozen_o    (frozen_o)
  );

  always #20 clk_i = ~clk_i; // 40 ns period

  always @(posedge clk_i)
  begin
    #2;
    net_ready_i = ($urandom % 100) < ready_duty;
  end

  // Skips comment and blank lines
  task automatic next_data_line(input int fd, output logic [8*LINE_LEN-1:0] line,
                                output bit found);
    logic [31:0] probe;
    int          code;
    found = 1'b0;
    line  = '0;
    while (!found && !$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code > 0 && $sscanf(line, "%h", probe) == 1)
        found = 1'b1;
    end
  endtask

  task automatic read_stimulus();
    int                    fd;
    int                    r;
    int                    w;
    int                    duty;
    bit                    found;
    logic [8*LINE_LEN-1:0] line;
    logic [31:0]           v0;
    logic [31:0]           v1;
    logic [31:0]           v2;
    logic [31:0]           v3;
    fd = $fopen("bench/mc_stimulus.txt", "r");
    if (fd == 0)
      stim_ok = 1'b0;
    for (r = 0; r < NUM_RUNS && stim_ok; r++)
    begin
      next_data_line(fd, line, found);
      if (!found || $sscanf(line, "%d", duty) != 1)
        stim_ok = 1'b0;
      duty_tbl[r] = duty;
      for (w = 0; w < `MC_MEM_WORDS; w += 4)
      begin
        next_data_line(fd, line, found);
        if (!found || $sscanf(line, "%h %h %h %h", v0, v1, v2, v3) != 4)
          stim_ok = 1'b0;
        prog_words[r][w]     = v0;
        prog_words[r][w + 1] = v1;
        prog_words[r][w + 2] = v2;
        prog_words[r][w + 3] = v3;
      end
      next_data_line(fd, line, found);
      if (!found || $sscanf(line, "%h %h %h %h", v0, v1, v2, v3) != 4)
        stim_ok = 1'b0;
      tile_ids[r][0] = v0;
      tile_ids[r][1] = v1;
      tile_ids[r][2] = v2;
      tile_ids[r][3] = v3;
    end
    if (fd != 0)
      $fclose(fd);
    if (!stim_ok)
    begin
      $display("Stimulus file bench/mc_stimulus.txt is missing, incomplete or malformed");
      error_count++;
    end
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string name);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic write_and_start(input int run);
    int a;
    for (a = 0; a < `MC_MEM_WORDS; a++)
    begin
      @(posedge clk_i);
      #2;
      prog_we_i   = 1'b1;
      prog_addr_i = `MC_ADDR_W'(a);
      prog_data_i = prog_words[run][a];
    end
    @(posedge clk_i);
    #2;
    prog_we_i = 1'b0;
    start_i   = 1'b1;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
  endtask

  task automatic wait_load_done(input bit after_reset);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (done_o !== 1'b1)
    begin
      cycles++;
      if (!after_reset)
        check_value(32'(frozen_o), 32'd0, "frozen_o of released tiles during reload");
      else
      begin
        // No unfreeze packet can leave before all stores are sent
        if (cycles <= STORES)
          check_value(32'(frozen_o), ALL_FROZEN, "frozen_o during stores");
        check_value(32'(frozen_o[`MC_NUM_TILES-1]), 32'd1,
                    "frozen_o of last tile before done_o");
      end
      @(negedge clk_i);
    end
    while (frozen_o !== '0)
    begin
      check_value(32'(done_o), 32'd1, "done_o while tiles unfreeze");
      @(negedge clk_i);
    end
  endtask

  task automatic check_contents(input int run);
    int          a;
    int          t;
    logic [31:0] expected;
    for (a = 0; a < `MC_MEM_WORDS; a++)
    begin
      @(posedge clk_i);
      #2;
      rd_addr_i = `MC_ADDR_W'(a);
      @(negedge clk_i);
      for (t = 0; t < `MC_NUM_TILES; t++)
      begin
        expected = (a == `MC_TILE_ID_PTR) ? tile_ids[run][t] : prog_words[run][a];
        check_value(rd_data_o[t], expected, $sformatf("rd_data_o[%0d] at word %0d", t, a));
      end
    end
  endtask

  initial
  begin
    int run;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    prog_we_i   = 1'b0;
    prog_addr_i = '0;
    prog_data_i = '0;
    start_i     = 1'b0;
    net_ready_i = 1'b1;
    rd_addr_i   = '0;
    ready_duty  = 100;
    error_count = 0;
    check_count = 0;
    stim_ok     = 1'b1;
    void'($urandom(SEED));
    read_stimulus();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    if (stim_ok)
    begin
      @(negedge clk_i);
      check_value(32'(done_o), 32'd0, "done_o after reset");
      check_value(32'(frozen_o), ALL_FROZEN, "frozen_o after reset");
      for (run = 0; run < NUM_RUNS; run++)
      begin
        ready_duty = duty_tbl[run];
        write_and_start(run);
        wait_load_done(run == 0); // Only the first run starts from reset
        check_contents(run);
      end
      // Reset part way into a reload of the first image
      write_and_start(0);
      repeat (20) @(posedge clk_i);
      #2;
      reset_i = 1'b1;
      repeat (RESET_CYCLES - 1) @(posedge clk_i);
      @(negedge clk_i);
      check_value(32'(done_o), 32'd0, "done_o after mid-load reset");
      check_value(32'(frozen_o), ALL_FROZEN, "frozen_o after mid-load reset");
      @(posedge clk_i);
      #2;
      reset_i = 1'b0;
      write_and_start(0);
      wait_load_done(1'b1);
      check_contents(0);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles: done_o or the tile unfreeze never arrived",
             WATCHDOG_CYCLES);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/mc_pkg.sv
logic/mc_program_ram.sv
logic/mc_spmd_loader.sv
logic/mc_link_stage.sv
logic/mc_tile_mem.sv
logic/mc_loader_top.sv
bench/tb_mc_loader.sv

//--- Makefile
# Verilator build and run of the SPMD loader testbench
VERILATOR ?= verilator
TOP       ?= tb_mc_loader
LINT_TOP  ?= mc_loader_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
SEED      ?= 0
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides the result, since tee hides the simulator's exit status
run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "No verdict found in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mc_stimulus.txt
# Each run: ready duty in percent (decimal), then 16 program words in hex,
# four per line from address 0, then the expected tile-id words of tiles 0 to 3
# run 1, no back-pressure
100
00000013 3c010000 34210100 a5a50003
8c220000 00431820 ac230004 1000ffff
20420001 00000000 7f7f0a0a 12345678
0badc0de 55aa55aa fedcba98 0f0f0f0f
00000000 00000001 00000002 00000003
# run 2, random back-pressure
55
9e3779b9 7f4a7c15 f39cc060 5ced4b3a
2545f491 4f1bbcdc 6a09e667 bb67ae85
3c6ef372 a54ff53a 510e527f 9b05688c
1f83d9ab 5be0cd19 cbbb9d5d 629a292a
00000000 00000001 00000002 00000003
